/* hw/vio_macros.svh */
`ifndef VIO_MACROS_SVH
`define VIO_MACROS_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////
`define VIO_SAMPLE_W 16
`define VIO_ATT_W 5
`define VIO_HOST_W 16
`define VIO_LED_W 8
`define VIO_SYNC_CNT_W 16

// Host command codes, low byte of the first word
`define VIO_CMD_CFG 8'h01
`define VIO_CMD_LED 8'h25
`define VIO_CMD_VOL 8'h26

// Composite sync enable inside the config word
`define VIO_CFG_CSYNC_BIT 3

`endif

/* hw/vio_pkg.sv */
`include "vio_macros.svh"

package vio_pkg;

	// Commands understood by the decoder
	typedef enum logic [7:0] {
		CMD_NONE = 8'h00,
		CMD_CFG  = `VIO_CMD_CFG,
		CMD_LED  = `VIO_CMD_LED,
		CMD_VOL  = `VIO_CMD_VOL
	} host_cmd_e;

	// Idle until a command word, then data words
	typedef enum logic {
		DEC_IDLE = 1'b0,
		DEC_DATA = 1'b1
	} dec_state_e;

	// Stereo cross-feed amount
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_25   = 2'd1,
		MIX_50   = 2'd2,
		MIX_MONO = 2'd3
	} mix_mode_e;

	typedef logic signed [`VIO_SAMPLE_W-1:0] sample_t;

	// Bit 4 mutes, bits 3:0 are a right shift
	typedef logic [`VIO_ATT_W-1:0] att_t;

endpackage

/* hw/vio_cfg_if.sv */
`include "vio_macros.svh"

interface vio_cfg_if;
	import vio_pkg::*;

	logic                  csync_en;
	att_t                  vol_att;
	logic [`VIO_LED_W-1:0] led_overtake;
	logic [`VIO_LED_W-1:0] led_state;

	// Written by the command decoder
	modport source (
		output csync_en,
		output vol_att,
		output led_overtake,
		output led_state
	);

	// Mixers, sync select and LED logic
	modport sink (
		input csync_en,
		input vol_att,
		input led_overtake,
		input led_state
	);

endinterface

/* hw/host_cmd_decoder.sv */
`include "vio_macros.svh"

module host_cmd_decoder (
	input  logic                   clk,
	input  logic                   resetd,
	input  logic                   i_io_sel,
	input  logic                   i_io_clk,
	input  logic [`VIO_HOST_W-1:0] i_io_din,
	output logic                   o_io_ack,
	vio_cfg_if.source              cfg
);
	import vio_pkg::*;

	logic                   clk_d;
	logic                   io_strobe;
	logic                   strobe_q;
	logic [`VIO_HOST_W-1:0] din_q;
	dec_state_e             state;
	host_cmd_e              cmd;

	////////////////////////////////////////////////////////////
	// Strobe and acknowledge
	////////////////////////////////////////////////////////////

	// One write per rising host toggle
	assign io_strobe = i_io_clk & ~clk_d;

	// clk_d doubles as the first ack stage
	always_ff @(posedge clk) begin
		if (resetd) begin
			clk_d    <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			clk_d    <= i_io_clk;
			o_io_ack <= clk_d;
		end
	end

	////////////////////////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		strobe_q <= io_strobe;
		din_q    <= i_io_din;

		if (!i_io_sel) begin
			state <= DEC_IDLE;
			cmd   <= CMD_NONE;
		end else if (strobe_q && state == DEC_IDLE) begin
			state <= DEC_DATA;
			// Unknown codes park on CMD_NONE so their data is dropped
			case (din_q[7:0])
				`VIO_CMD_CFG: cmd <= CMD_CFG;
				`VIO_CMD_LED: cmd <= CMD_LED;
				`VIO_CMD_VOL: cmd <= CMD_VOL;
				default:      cmd <= CMD_NONE;
			endcase
		end
	end

	// Data words land one cycle after the strobe edge
	always_ff @(posedge clk) begin
		if (resetd) begin
			cfg.csync_en     <= 1'b0;
			cfg.vol_att      <= '0;
			cfg.led_overtake <= '0;
			cfg.led_state    <= '0;
		end else if (i_io_sel && strobe_q && state == DEC_DATA) begin
			case (cmd)
				CMD_CFG: cfg.csync_en <= din_q[`VIO_CFG_CSYNC_BIT];
				CMD_LED: begin
					cfg.led_overtake <= din_q[2*`VIO_LED_W-1:`VIO_LED_W];
					cfg.led_state    <= din_q[`VIO_LED_W-1:0];
				end
				CMD_VOL: cfg.vol_att <= din_q[`VIO_ATT_W-1:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Host handshake relies on a fixed two-cycle echo
	a_ack_delay: assert property (@(posedge clk) disable iff (resetd)
		(!$past(resetd) && !$past(resetd, 2)) |-> (o_io_ack == $past(i_io_clk, 2)));

	// Deselect always aborts a transaction
	a_sel_idle: assert property (@(posedge clk)
		!i_io_sel |=> state == DEC_IDLE);

endmodule

/* hw/sync_polarity_fix.sv */
`include "vio_macros.svh"

module sync_polarity_fix (
	input  logic clk,
	input  logic i_sync,
	output logic o_sync
);

	logic                       s1;
	logic                       s2;
	logic [`VIO_SYNC_CNT_W-1:0] cnt;
	logic [`VIO_SYNC_CNT_W-1:0] hi_len;
	logic [`VIO_SYNC_CNT_W-1:0] lo_len;
	logic                       pol;

	// Short phase ends up high
	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk) begin
		s1 <= i_sync;
		s2 <= s1;

		// Phase length since the last edge
		if (s2 != s1) begin
			cnt <= '0;
		end else if (~&cnt) begin
			cnt <= cnt + 1'b1;
		end

		// Rising edge closes a low phase
		if (~s2 & s1) begin
			lo_len <= cnt;
		end

		// Falling edge closes a high phase
		if (s2 & ~s1) begin
			hi_len <= cnt;
		end

		pol <= hi_len > lo_len;
	end

endmodule

/* hw/csync_gen.sv */
`include "vio_macros.svh"

module csync_gen (
	input  logic clk,
	input  logic i_hsync,
	input  logic i_vsync,
	output logic o_csync
);

	logic                       prev_hs;
	logic [`VIO_SYNC_CNT_W-1:0] h_cnt;
	logic [`VIO_SYNC_CNT_W-1:0] line_len;
	logic [`VIO_SYNC_CNT_W-1:0] hs_len;
	logic                       cs_hs;
	logic                       cs_vs;

	// Vsync inverts the serrated hsync train
	assign o_csync = cs_hs ^ cs_vs;

	////////////////////////////////////////////////////////////
	// Line and hsync measurement
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		prev_hs <= i_hsync;
		h_cnt   <= h_cnt + 1'b1;

		if (prev_hs != i_hsync) begin
			h_cnt <= '0;
			if (i_hsync) begin
				// Low phase less one pulse, counted from the falling edge
				line_len <= h_cnt - hs_len;
			end else begin
				hs_len <= h_cnt;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Composite hsync part
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!i_vsync) begin
			cs_hs <= i_hsync;
		end else if (h_cnt == line_len) begin
			// Pulse moved one hsync length ahead of the line end
			cs_hs <= 1'b1;
		end else if (!prev_hs && i_hsync) begin
			cs_hs <= 1'b0;
		end

		cs_vs <= i_vsync;
	end

endmodule

/* hw/audio_mixer.sv */
`include "vio_macros.svh"

module audio_mixer (
	input  logic                     clk,
	input  logic [`VIO_SAMPLE_W-1:0] i_core,
	input  logic                     i_is_signed,
	input  vio_pkg::sample_t         i_host,
	input  vio_pkg::sample_t         i_pre_in,
	input  vio_pkg::mix_mode_e       i_mix,
	vio_cfg_if.sink                  cfg,
	output vio_pkg::sample_t         o_pre_out,
	output vio_pkg::sample_t         o_out
);
	import vio_pkg::*;

	logic [`VIO_SAMPLE_W-1:0] core_d1;
	logic [`VIO_SAMPLE_W-1:0] core_d2;
	logic [`VIO_SAMPLE_W-1:0] core_d3;
	logic [`VIO_SAMPLE_W-1:0] ca;
	logic signed [`VIO_SAMPLE_W:0] core_ext;
	logic signed [`VIO_SAMPLE_W:0] sum;
	logic signed [`VIO_SAMPLE_W:0] mixed;
	logic signed [`VIO_SAMPLE_W:0] scaled;

	////////////////////////////////////////////////////////////
	// Core sample stabilizer
	////////////////////////////////////////////////////////////

	// Core may change bits on different cycles
	always_ff @(posedge clk) begin
		core_d1 <= i_core;
		core_d2 <= core_d1;
		core_d3 <= core_d2;
		if (core_d1 == core_d2 && core_d2 == core_d3) begin
			ca <= core_d3;
		end
	end

	// Unsigned core audio is halved into the signed range
	assign core_ext = i_is_signed ? {ca[`VIO_SAMPLE_W-1], ca} : {2'b00, ca[`VIO_SAMPLE_W-1:1]};

	////////////////////////////////////////////////////////////
	// Sum, cross-feed, volume, clamp
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		sum       <= core_ext + {i_host[`VIO_SAMPLE_W-1], i_host};
		o_pre_out <= sum[`VIO_SAMPLE_W:1];

		case (i_mix)
			MIX_NONE: mixed <= sum;
			MIX_25:   mixed <= sum - (sum >>> 3) + (i_pre_in >>> 2);
			MIX_50:   mixed <= sum - (sum >>> 2) + (i_pre_in >>> 1);
			MIX_MONO: mixed <= (sum >>> 1) + i_pre_in;
			default:  mixed <= sum;
		endcase

		if (cfg.vol_att[`VIO_ATT_W-1]) begin
			scaled <= '0;
		end else begin
			scaled <= mixed >>> cfg.vol_att[`VIO_ATT_W-2:0];
		end

		// Saturate on 17 to 16 bit overflow
		if (scaled[`VIO_SAMPLE_W] != scaled[`VIO_SAMPLE_W-1]) begin
			o_out <= {scaled[`VIO_SAMPLE_W], {(`VIO_SAMPLE_W-1){~scaled[`VIO_SAMPLE_W]}}};
		end else begin
			o_out <= scaled[`VIO_SAMPLE_W-1:0];
		end
	end

	// Mute from the decoder reaches the output within the pipeline depth
	a_mute: assert property (@(posedge clk)
		cfg.vol_att[`VIO_ATT_W-1] [*10] |-> o_out == '0);

endmodule

/* hw/vio_top.sv */
`include "vio_macros.svh"

module vio_top (
	input  logic                     clk,
	input  logic                     resetd,
	input  logic                     i_io_sel,
	input  logic                     i_io_clk,
	input  logic [`VIO_HOST_W-1:0]   i_io_din,
	input  logic [`VIO_SAMPLE_W-1:0] i_core_l,
	input  logic [`VIO_SAMPLE_W-1:0] i_core_r,
	input  logic                     i_is_signed,
	input  logic [`VIO_SAMPLE_W-1:0] i_host_l,
	input  logic [`VIO_SAMPLE_W-1:0] i_host_r,
	input  logic [1:0]               i_mix,
	input  logic                     i_hs_raw,
	input  logic                     i_vs_raw,
	output logic                     o_io_ack,
	output logic [`VIO_SAMPLE_W-1:0] o_audio_l,
	output logic [`VIO_SAMPLE_W-1:0] o_audio_r,
	output logic [`VIO_LED_W-1:0]    o_led,
	output logic                     o_hs,
	output logic                     o_vs,
	output logic                     o_sync
);
	import vio_pkg::*;

	// No board status LEDs behind the override
	localparam logic [`VIO_LED_W-1:0] led_default = '0;

	mix_mode_e mix_mode;
	sample_t   pre_l;
	sample_t   pre_r;
	logic      csync;

	vio_cfg_if cfg ();

	assign mix_mode = mix_mode_e'(i_mix);

	host_cmd_decoder u_decoder (
		.clk      (clk),
		.resetd   (resetd),
		.i_io_sel (i_io_sel),
		.i_io_clk (i_io_clk),
		.i_io_din (i_io_din),
		.o_io_ack (o_io_ack),
		.cfg      (cfg.source)
	);

	////////////////////////////////////////////////////////////
	// Audio
	////////////////////////////////////////////////////////////

	// Each channel feeds half its sum to the other
	audio_mixer u_mix_l (
		.clk         (clk),
		.i_core      (i_core_l),
		.i_is_signed (i_is_signed),
		.i_host      (i_host_l),
		.i_pre_in    (pre_r),
		.i_mix       (mix_mode),
		.cfg         (cfg.sink),
		.o_pre_out   (pre_l),
		.o_out       (o_audio_l)
	);

	audio_mixer u_mix_r (
		.clk         (clk),
		.i_core      (i_core_r),
		.i_is_signed (i_is_signed),
		.i_host      (i_host_r),
		.i_pre_in    (pre_l),
		.i_mix       (mix_mode),
		.cfg         (cfg.sink),
		.o_pre_out   (pre_r),
		.o_out       (o_audio_r)
	);

	////////////////////////////////////////////////////////////
	// Video sync
	////////////////////////////////////////////////////////////

	sync_polarity_fix u_fix_h (
		.clk    (clk),
		.i_sync (i_hs_raw),
		.o_sync (o_hs)
	);

	sync_polarity_fix u_fix_v (
		.clk    (clk),
		.i_sync (i_vs_raw),
		.o_sync (o_vs)
	);

	csync_gen u_csync (
		.clk     (clk),
		.i_hsync (o_hs),
		.i_vsync (o_vs),
		.o_csync (csync)
	);

	assign o_sync = cfg.csync_en ? csync : o_hs;

	assign o_led = (cfg.led_overtake & cfg.led_state) | (~cfg.led_overtake & led_default);

endmodule

/* dv/vio_tb.sv */
`include "vio_macros.svh"

module vio_tb;
	import vio_pkg::*;

	// Raw video timing, sync pulses are active low at the source
	localparam int line_len    = 40;
	localparam int hs_len      = 6;
	localparam int frame_lines = 10;
	localparam int vs_first    = 4;
	localparam int vs_lines    = 3;
	localparam int frame_len   = line_len * frame_lines;

	logic                     clk = 1'b0;
	logic                     resetd;
	logic                     i_io_sel;
	logic                     i_io_clk;
	logic [`VIO_HOST_W-1:0]   i_io_din;
	logic [`VIO_SAMPLE_W-1:0] i_core_l;
	logic [`VIO_SAMPLE_W-1:0] i_core_r;
	logic                     i_is_signed;
	logic [`VIO_SAMPLE_W-1:0] i_host_l;
	logic [`VIO_SAMPLE_W-1:0] i_host_r;
	logic [1:0]               i_mix;
	logic                     i_hs_raw;
	logic                     i_vs_raw;
	logic                     o_io_ack;
	logic [`VIO_SAMPLE_W-1:0] o_audio_l;
	logic [`VIO_SAMPLE_W-1:0] o_audio_r;
	logic [`VIO_LED_W-1:0]    o_led;
	logic                     o_hs;
	logic                     o_vs;
	logic                     o_sync;

	logic [31:0]              lfsr_state;
	att_t                     att_now;
	logic                     io_clk_d1;
	logic                     io_clk_d2;
	logic                     hs_d;
	logic                     vs_d;
	logic                     led_check;
	logic                     audio_check;
	logic                     sync_check;
	logic                     sync_direct_check;
	logic                     sync_delay_check;
	logic [`VIO_LED_W-1:0]    led_exp;
	logic [`VIO_SAMPLE_W-1:0] exp_l;
	logic [`VIO_SAMPLE_W-1:0] exp_r;

	always #4 clk = ~clk;

	vio_top UUT (.*);

	// Reference delays for the ack echo and the csync path
	always @(posedge clk) begin
		if (resetd) begin
			io_clk_d1 <= 1'b0;
			io_clk_d2 <= 1'b0;
		end else begin
			io_clk_d1 <= i_io_clk;
			io_clk_d2 <= io_clk_d1;
		end
		hs_d <= o_hs;
		vs_d <= o_vs;
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	a_reset: assert property (@(posedge clk) $fell(resetd) |=> (o_io_ack == 1'b0 && o_led == '0))
		else report_mismatch("reset", 32'd0, {23'd0, $sampled(o_io_ack), $sampled(o_led)});
	a_ack: assert property (@(posedge clk) disable iff (resetd) o_io_ack == io_clk_d2)
		else report_mismatch("ack", $sampled(io_clk_d2), $sampled(o_io_ack));
	a_led: assert property (@(posedge clk) led_check |-> o_led == led_exp)
		else report_mismatch("led", $sampled(led_exp), $sampled(o_led));
	a_audio_l: assert property (@(posedge clk) audio_check |-> o_audio_l == exp_l)
		else report_mismatch("audio_l", $sampled(exp_l), $sampled(o_audio_l));
	a_audio_r: assert property (@(posedge clk) audio_check |-> o_audio_r == exp_r)
		else report_mismatch("audio_r", $sampled(exp_r), $sampled(o_audio_r));
	a_hs: assert property (@(posedge clk) sync_check |-> o_hs == !i_hs_raw)
		else report_mismatch("hs_polarity", !$sampled(i_hs_raw), $sampled(o_hs));
	a_vs: assert property (@(posedge clk) sync_check |-> o_vs == !i_vs_raw)
		else report_mismatch("vs_polarity", !$sampled(i_vs_raw), $sampled(o_vs));
	a_sync_direct: assert property (@(posedge clk) sync_direct_check |-> o_sync == o_hs)
		else report_mismatch("sync_direct", $sampled(o_hs), $sampled(o_sync));
	a_sync_delay: assert property (@(posedge clk)
		sync_delay_check && !o_vs && !vs_d |-> o_sync == hs_d)
		else report_mismatch("csync", $sampled(hs_d), $sampled(o_sync));

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("error %s expected %h actual %h", name, expected, actual);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	////////////////////////////////////////////////////////////
	// Reference models and random source
	////////////////////////////////////////////////////////////

	// Taps 32 22 2 1, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		logic        fb;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [15:0] random_word();
		logic [31:0] r;
		r = lfsr_bits(16);
		return r[15:0];
	endfunction

	// Unsigned core audio counts half
	function automatic int channel_sum(input logic [15:0] core, input logic [15:0] host,
		input logic is_signed);
		int c;
		if (is_signed) begin
			c = $signed(core);
		end else begin
			c = int'(core >> 1);
		end
		return c + $signed(host);
	endfunction

	function automatic logic [15:0] expect_out(input int own, input int other,
		input logic [1:0] mix, input att_t att);
		int v;
		if (mix == MIX_MONO) begin
			v = (own >>> 1) + (other >>> 1);
		end else begin
			v = own;
		end
		if (att[4]) begin
			v = 0;
		end else begin
			v = v >>> att[3:0];
		end
		if (v > 32767) begin
			v = 32767;
		end else if (v < -32768) begin
			v = -32768;
		end
		return v[15:0];
	endfunction

	////////////////////////////////////////////////////////////
	// Host bus
	////////////////////////////////////////////////////////////

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (o_io_ack !== level) begin
			if (n >= 20) begin
				$display("TEST FAIL");
				$fatal(1, "acknowledge never arrived");
			end else begin
				@(negedge clk);
				n++;
			end
		end
	endtask

	// One word is one rising host toggle
	task automatic write_word(input logic [15:0] word);
		i_io_din = word;
		i_io_clk = 1'b1;
		wait_ack(1'b1);
		i_io_clk = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic host_command(input logic [7:0] cmd, input logic [15:0] data);
		i_io_sel = 1'b1;
		write_word({8'h00, cmd});
		write_word(data);
		i_io_sel = 1'b0;
		@(negedge clk);
	endtask

	task automatic set_volume(input att_t att);
		audio_check = 1'b0;
		host_command(CMD_VOL, {11'd0, att});
		att_now = att;
	endtask

	// Random steady samples, then check after settling
	task automatic audio_case(input logic is_signed, input mix_mode_e mix);
		int sum_l;
		int sum_r;
		audio_check = 1'b0;
		i_core_l    = random_word();
		i_core_r    = random_word();
		i_host_l    = random_word();
		i_host_r    = random_word();
		i_is_signed = is_signed;
		i_mix       = mix;
		sum_l = channel_sum(i_core_l, i_host_l, is_signed);
		sum_r = channel_sum(i_core_r, i_host_r, is_signed);
		exp_l = expect_out(sum_l, sum_r, mix, att_now);
		exp_r = expect_out(sum_r, sum_l, mix, att_now);
		repeat (10) @(negedge clk);
		audio_check = 1'b1;
		repeat (4) @(negedge clk);
		audio_check = 1'b0;
	endtask

	// Inverted raw syncs, long high phase and short low pulse
	initial begin : sync_source
		int row;
		int col;
		forever begin
			for (row = 0; row < frame_lines; row++) begin
				for (col = 0; col < line_len; col++) begin
					@(negedge clk);
					i_hs_raw = col >= hs_len;
					i_vs_raw = !(row >= vs_first && row < vs_first + vs_lines);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [15:0] word;
		lfsr_state        = 32'h0a7f0e70;
		resetd            = 1'b1;
		i_io_sel          = 1'b0;
		// Host strobe parked high through reset so the ack reset shows
		i_io_clk          = 1'b1;
		i_io_din          = '0;
		i_core_l          = '0;
		i_core_r          = '0;
		i_is_signed       = 1'b1;
		i_host_l          = '0;
		i_host_r          = '0;
		i_mix             = MIX_NONE;
		i_hs_raw          = 1'b1;
		i_vs_raw          = 1'b1;
		att_now           = '0;
		led_exp           = '0;
		exp_l             = '0;
		exp_r             = '0;
		led_check         = 1'b0;
		audio_check       = 1'b0;
		sync_check        = 1'b0;
		sync_direct_check = 1'b0;
		sync_delay_check  = 1'b0;
		repeat (10) @(negedge clk);
		resetd   = 1'b0;
		i_io_clk = 1'b0;
		repeat (2) @(negedge clk);

		// LED override, unknown command data must not disturb it
		repeat (8) begin
			word = random_word();
			led_check = 1'b0;
			host_command(CMD_LED, word);
			led_exp   = word[15:8] & word[7:0];
			led_check = 1'b1;
			host_command(8'h7e, random_word());
		end
		led_check = 1'b0;

		// Volume with signed samples
		set_volume(5'd0);
		audio_case(1'b1, MIX_NONE);
		audio_case(1'b0, MIX_NONE);
		set_volume(5'd1);
		audio_case(1'b1, MIX_NONE);
		set_volume(5'd3);
		audio_case(1'b1, MIX_NONE);
		set_volume(5'd7);
		audio_case(1'b1, MIX_NONE);
		set_volume(5'd15);
		audio_case(1'b1, MIX_NONE);
		set_volume(5'd16);
		audio_case(1'b1, MIX_NONE);
		set_volume(5'd23);
		audio_case(1'b1, MIX_NONE);

		// Cross-feed between the channels
		set_volume(5'd0);
		repeat (4) audio_case(1'b1, MIX_MONO);
		set_volume(5'd2);
		audio_case(1'b1, MIX_MONO);

		// Sync normalization, then composite sync
		repeat (3 * frame_len) @(negedge clk);
		sync_check        = 1'b1;
		sync_direct_check = 1'b1;
		repeat (frame_len) @(negedge clk);
		sync_direct_check = 1'b0;
		host_command(CMD_CFG, 16'h0001 << `VIO_CFG_CSYNC_BIT);
		sync_delay_check = 1'b1;
		repeat (2 * frame_len) @(negedge clk);
		sync_delay_check = 1'b0;
		sync_check       = 1'b0;

		$display("TEST PASS");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+hw
hw/vio_pkg.sv
hw/vio_cfg_if.sv
hw/host_cmd_decoder.sv
hw/sync_polarity_fix.sv
hw/csync_gen.sv
hw/audio_mixer.sv
hw/vio_top.sv
dv/vio_tb.sv

/* Bender.yml */
package:
  name: vio_glue

sources:
  # Design sources
  - target: any(synthesis, simulation)
    include_dirs:
      - hw
    files:
      - hw/vio_pkg.sv
      - hw/vio_cfg_if.sv
      - hw/host_cmd_decoder.sv
      - hw/sync_polarity_fix.sv
      - hw/csync_gen.sv
      - hw/audio_mixer.sv
      - hw/vio_top.sv

  # Testbench
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/vio_tb.sv
